// ==== bench/tb_i2c_target.sv ====
/*
 * Testbench for the I2C target
 * Random master transactions against a register model and an attached memory
 */
`default_nettype none

module tb_i2c_target
    import i2c_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS     = 10;
    localparam int HALF       = 20;
    localparam int QUARTER    = HALF / 2;
    localparam int N_TXN      = 200;
    localparam int SEED       = 44114;
    localparam int BASE_ADDR  = 'h08;
    localparam int LAST_REG   = 'h24;
    localparam int RO_FIRST   = 3;
    localparam int RO_LAST    = 5;
    localparam int STROBE_LEN = 3;
    localparam int MEM_SIZE   = LAST_REG + 1;
    localparam int SCL_NS     = 2 * HALF * CLK_NS;
    // Up to two bus transfers of about 30 SCL periods per transaction
    localparam int WATCHDOG_NS = N_TXN * 2 * 30 * SCL_NS + 20000;

    logic       clk;
    logic       rst_n;
    logic       scl_m;
    logic       sda_m;
    logic       sda_in;
    logic [2:0] addr_sel;
    data_t      data_in;
    logic       sda_drive_low;
    reg_addr_t  reg_addr;
    data_t      data_out;
    logic       reg_write;
    logic       reg_read;

    // Memory on the DUT side and the reference copy
    data_t      mem [MEM_SIZE];
    logic [7:0] exp_mem [MEM_SIZE];
    int         exp_ptr;

    int         errors;
    int         write_hi, write_edges, read_hi, read_edges, drive_hi;
    logic       write_prev, read_prev;
    reg_addr_t  wr_exp_addr;
    data_t      wr_exp_data;

    // Wired-AND of master and target
    assign sda_in  = sda_m & ~sda_drive_low;
    assign data_in = (reg_addr < MEM_SIZE) ? mem[reg_addr] : 8'h00;

    i2c_target u_i2c_target (
        .clk           (clk),
        .rst_n         (rst_n),
        .scl           (scl_m),
        .sda_in        (sda_in),
        .addr_sel      (addr_sel),
        .data_in       (data_in),
        .sda_drive_low (sda_drive_low),
        .reg_addr      (reg_addr),
        .data_out      (data_out),
        .reg_write     (reg_write),
        .reg_read      (reg_read)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Memory takes the write data while the strobe is high
    always @(posedge clk) begin
        if (reg_write && reg_addr < MEM_SIZE) mem[reg_addr] <= data_out;
    end

    // ======================================================================
    // Strobe and drive monitor sampled on the falling edge
    // ======================================================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (reg_write) begin
                write_hi++;
                if (reg_addr !== wr_exp_addr) report_mismatch("reg_addr", reg_addr, wr_exp_addr);
                if (data_out !== wr_exp_data) report_mismatch("data_out", data_out, wr_exp_data);
            end
            if (reg_write && !write_prev) write_edges++;
            if (reg_read) read_hi++;
            if (reg_read && !read_prev) read_edges++;
            if (sda_drive_low) drive_hi++;
            write_prev = reg_write;
            read_prev  = reg_read;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("Fail %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
    endtask

    task automatic clear_counts();
        write_hi    = 0;
        write_edges = 0;
        read_hi     = 0;
        read_edges  = 0;
        drive_hi    = 0;
    endtask

    function automatic logic [7:0] fill_value(input int idx);
        return 8'((idx * 59) ^ 165);
    endfunction

    function automatic logic [6:0] own_address();
        return 7'(BASE_ADDR + addr_sel);
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // ======================================================================
    // Master bus tasks
    // ======================================================================
    // Bus is idle on entry and SCL is low on exit
    task automatic bus_start();
        sda_m = 1'b1;
        scl_m = 1'b1;
        wait_clocks(HALF);
        sda_m = 1'b0;
        wait_clocks(HALF);
        scl_m = 1'b0;
    endtask

    task automatic bus_stop();
        wait_clocks(QUARTER);
        sda_m = 1'b0;
        wait_clocks(QUARTER);
        scl_m = 1'b1;
        wait_clocks(HALF);
        sda_m = 1'b1;
        wait_clocks(HALF);
    endtask

    // SDA moves mid-low and is sampled mid-high
    task automatic clock_bit(input logic value, output logic sampled);
        wait_clocks(QUARTER);
        sda_m = value;
        wait_clocks(QUARTER);
        scl_m = 1'b1;
        wait_clocks(QUARTER);
        sampled = sda_in;
        wait_clocks(QUARTER);
        scl_m = 1'b0;
    endtask

    // Returns the SDA level of the ACK slot where 0 is ACK
    task automatic send_byte(input logic [7:0] value, output logic ack_bit);
        logic echo;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(value[i], echo);
        end
        clock_bit(1'b1, ack_bit);
    endtask

    // One byte MSB first and then a NACK from the master
    task automatic recv_byte(output logic [7:0] value);
        logic echo;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(1'b1, value[i]);
        end
        clock_bit(1'b1, echo);
    endtask

    // ======================================================================
    // Transactions
    // ======================================================================
    task automatic write_txn();
        logic [7:0] reg_num;
        logic [7:0] wdata;
        logic       a0, a1, a2;
        do begin
            reg_num = 8'($urandom_range(0, LAST_REG));
        end while (reg_num >= RO_FIRST && reg_num <= RO_LAST);
        wdata       = 8'($urandom);
        wr_exp_addr = reg_num[5:0];
        wr_exp_data = wdata;
        clear_counts();
        bus_start();
        send_byte({own_address(), 1'b0}, a0);
        send_byte(reg_num, a1);
        send_byte(wdata, a2);
        bus_stop();
        if (a0 !== 1'b0) report_mismatch("sda address ack", a0, 0);
        if (a1 !== 1'b0) report_mismatch("sda register ack", a1, 0);
        if (a2 !== 1'b0) report_mismatch("sda data ack", a2, 0);
        if (write_hi != STROBE_LEN) report_mismatch("reg_write cycles", write_hi, STROBE_LEN);
        if (write_edges != 1) report_mismatch("reg_write strobes", write_edges, 1);
        exp_mem[reg_num] = wdata;
        exp_ptr          = reg_num;
        if (mem[reg_num] !== exp_mem[reg_num]) report_mismatch("mem", mem[reg_num], wdata);
    endtask

    task automatic ptr_read_txn();
        logic [7:0] reg_num;
        logic [7:0] rdata;
        logic       a0, a1, a2;
        reg_num = 8'($urandom_range(0, LAST_REG));
        clear_counts();
        bus_start();
        send_byte({own_address(), 1'b0}, a0);
        send_byte(reg_num, a1);
        bus_stop();
        if (a0 !== 1'b0) report_mismatch("sda address ack", a0, 0);
        if (a1 !== 1'b0) report_mismatch("sda register ack", a1, 0);
        if (write_hi != 0) report_mismatch("reg_write cycles", write_hi, 0);
        if (reg_addr !== reg_num[5:0]) report_mismatch("reg_addr", reg_addr, reg_num);
        exp_ptr = reg_num;
        clear_counts();
        bus_start();
        send_byte({own_address(), 1'b1}, a2);
        recv_byte(rdata);
        bus_stop();
        if (a2 !== 1'b0) report_mismatch("sda read address ack", a2, 0);
        if (rdata !== exp_mem[exp_ptr]) report_mismatch("sda read byte", rdata, exp_mem[exp_ptr]);
        if (read_edges != 1) report_mismatch("reg_read strobes", read_edges, 1);
        if (read_hi != STROBE_LEN) report_mismatch("reg_read cycles", read_hi, STROBE_LEN);
        if (write_hi != 0) report_mismatch("reg_write cycles", write_hi, 0);
    endtask

    // Foreign address gets a NACK and no drive until STOP
    task automatic bad_addr_txn();
        logic [6:0] addr;
        logic       a0, a1;
        do begin
            addr = 7'($urandom);
        end while (addr == own_address());
        clear_counts();
        bus_start();
        send_byte({addr, 1'($urandom)}, a0);
        send_byte(8'($urandom), a1);
        bus_stop();
        if (a0 !== 1'b1) report_mismatch("sda address ack", a0, 1);
        if (a1 !== 1'b1) report_mismatch("sda second byte ack", a1, 1);
        if (drive_hi != 0) report_mismatch("sda_drive_low cycles", drive_hi, 0);
        if (write_hi + read_hi != 0) report_mismatch("strobe cycles", write_hi + read_hi, 0);
    endtask

    task automatic high_reg_txn();
        logic [7:0] reg_num;
        logic       a0, a1;
        reg_num = 8'($urandom_range(LAST_REG + 1, 255));
        clear_counts();
        bus_start();
        send_byte({own_address(), 1'b0}, a0);
        send_byte(reg_num, a1);
        bus_stop();
        if (a0 !== 1'b0) report_mismatch("sda address ack", a0, 0);
        if (a1 !== 1'b1) report_mismatch("sda register ack", a1, 1);
        if (reg_addr !== 6'(exp_ptr)) report_mismatch("reg_addr", reg_addr, exp_ptr);
        if (write_hi != 0) report_mismatch("reg_write cycles", write_hi, 0);
    endtask

    // Read-only window moves the pointer and refuses the data
    task automatic ro_txn();
        logic [7:0] reg_num;
        logic       a0, a1, a2;
        reg_num = 8'($urandom_range(RO_FIRST, RO_LAST));
        clear_counts();
        bus_start();
        send_byte({own_address(), 1'b0}, a0);
        send_byte(reg_num, a1);
        send_byte(8'($urandom), a2);
        bus_stop();
        exp_ptr = reg_num;
        if (a0 !== 1'b0) report_mismatch("sda address ack", a0, 0);
        if (a1 !== 1'b0) report_mismatch("sda register ack", a1, 0);
        if (a2 !== 1'b1) report_mismatch("sda data ack", a2, 1);
        if (write_hi != 0) report_mismatch("reg_write cycles", write_hi, 0);
        if (mem[reg_num] !== exp_mem[reg_num]) begin
            report_mismatch("mem", mem[reg_num], exp_mem[reg_num]);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        scl_m      = 1'b1;
        sda_m      = 1'b1;
        addr_sel   = 3'd0;
        errors     = 0;
        write_prev = 1'b0;
        read_prev  = 1'b0;
        exp_ptr    = 0;
        clear_counts();
        for (int i = 0; i < MEM_SIZE; i++) begin
            mem[i]     <= fill_value(i);
            exp_mem[i] = fill_value(i);
        end
        wait_clocks(16);
        rst_n = 1'b1;
        wait_clocks(2);
        if (sda_drive_low !== 1'b0) report_mismatch("sda_drive_low", sda_drive_low, 0);
        if (reg_write !== 1'b0) report_mismatch("reg_write", reg_write, 0);
        if (reg_read !== 1'b0) report_mismatch("reg_read", reg_read, 0);
        if (reg_addr !== 6'h00) report_mismatch("reg_addr", reg_addr, 0);
        if (data_out !== 8'h00) report_mismatch("data_out", data_out, 0);
        for (int n = 0; n < N_TXN; n++) begin
            // Straps change only while the bus is idle
            addr_sel = 3'($urandom);
            case ($urandom_range(0, 4))
                0: write_txn();
                1: ptr_read_txn();
                2: bad_addr_txn();
                3: high_reg_txn();
                default: ro_txn();
            endcase
        end
        $display("Checks done after %0d transactions, %0d error(s)", N_TXN, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: transactions did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/bus_monitor.sv ====
/*
 * I2C bus monitor
 * Synchronizes SCL and SDA and flags SCL edges, START and STOP
 */
`default_nettype none

`include "i2c_macros.svh"

module bus_monitor (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic scl,
    input  wire logic sda_in,
    output logic      sda_sync,
    output logic      scl_rise,
    output logic      scl_fall,
    output logic      start_det,
    output logic      stop_det
);

    localparam int STAGES = `I2C_SYNC_STAGES;

    // Newest sample in bit 0 and oldest in the top bit
    logic [STAGES-1:0] scl_q;
    logic [STAGES-1:0] sda_q;

    // ======================================================================
    // Pin synchronizers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Idle bus is high on both lines
            scl_q <= '1;
            sda_q <= '1;
        end else begin
            scl_q <= {scl_q[STAGES-2:0], scl};
            sda_q <= {sda_q[STAGES-2:0], sda_in};
        end
    end

    assign sda_sync = sda_q[STAGES-1];

    // ======================================================================
    // Edge and condition pulses
    // ======================================================================
    // Compare the two oldest stages and register the result
    // Pulse lands STAGES clocks after the pin change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else begin
            scl_rise  <= (scl_q[STAGES-1:STAGES-2] == 2'b01);
            scl_fall  <= (scl_q[STAGES-1:STAGES-2] == 2'b10);
            // START is SDA falling with SCL high
            start_det <= (sda_q[STAGES-1:STAGES-2] == 2'b10) && scl_q[STAGES-1];
            // STOP is SDA rising with SCL high
            stop_det  <= (sda_q[STAGES-1:STAGES-2] == 2'b01) && scl_q[STAGES-1];
        end
    end

    // SDA must hold still in the sample where SCL falls
    a_cond_off_edge: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((start_det || stop_det) && scl_fall)
    );

endmodule

`default_nettype wire

// ==== logic/i2c_macros.svh ====
/*
 * I2C target constants for addressing, the register map, widths and strobe timing
 */
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// ======================================================================
// Addressing and register map
// ======================================================================

// Device address with all three straps tied low
`define I2C_ADDR_BASE 7'h08

// Highest register number that the memory holds
`define I2C_LAST_REG 8'h24

// Read-only window with both ends included
`define I2C_RO_FIRST 8'h03
`define I2C_RO_LAST 8'h05

// ======================================================================
// Widths and timing
// ======================================================================
`define I2C_STROBE_CYCLES 3
`define I2C_SYNC_STAGES 3
`define I2C_REG_AW 6
`define I2C_DATA_W 8

`endif

// ==== logic/i2c_pkg.sv ====
/*
 * Shared types of the I2C target
 */
`default_nettype none

`include "i2c_macros.svh"

package i2c_pkg;

    // Target FSM states, one per bus phase
    typedef enum logic [3:0] {
        IDLE,
        DEV_ADDR,
        R_W,
        ACK_ADDR,
        DEV_REG,
        ACK_REG,
        DATA_W,
        ACK_DATA,
        DATA_R,
        NACK,
        WAIT
    } target_state_e;

    // Direction from the R/W bit of the address byte
    typedef enum logic {
        WRITE = 1'b0,
        READ  = 1'b1
    } xfer_dir_e;

    typedef logic [`I2C_DATA_W-1:0] data_t;
    typedef logic [`I2C_REG_AW-1:0] reg_addr_t;

endpackage

`default_nettype wire

// ==== logic/i2c_target.sv ====
/*
 * I2C target top level
 */
`default_nettype none

module i2c_target
    import i2c_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       scl,
    input  wire logic       sda_in,
    input  wire logic [2:0] addr_sel,
    input  wire data_t      data_in,
    output logic            sda_drive_low,
    output reg_addr_t       reg_addr,
    output data_t           data_out,
    output logic            reg_write,
    output logic            reg_read
);

    // Monitor to FSM
    logic  sda_sync;
    logic  scl_rise;
    logic  scl_fall;
    logic  start_det;
    logic  stop_det;

    // FSM to register port
    data_t rx_byte;
    logic  ptr_load;
    logic  wr_load;
    logic  rd_start;

    bus_monitor u_bus_monitor (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl       (scl),
        .sda_in    (sda_in),
        .sda_sync  (sda_sync),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det)
    );

    // Read data comes straight from the memory port
    target_fsm u_target_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .sda_sync      (sda_sync),
        .scl_rise      (scl_rise),
        .scl_fall      (scl_fall),
        .start_det     (start_det),
        .stop_det      (stop_det),
        .addr_sel      (addr_sel),
        .data_in       (data_in),
        .sda_drive_low (sda_drive_low),
        .rx_byte       (rx_byte),
        .ptr_load      (ptr_load),
        .wr_load       (wr_load),
        .rd_start      (rd_start)
    );

    reg_port u_reg_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .ptr_load  (ptr_load),
        .wr_load   (wr_load),
        .rd_start  (rd_start),
        .rx_byte   (rx_byte),
        .reg_addr  (reg_addr),
        .data_out  (data_out),
        .reg_write (reg_write),
        .reg_read  (reg_read)
    );

endmodule

`default_nettype wire

// ==== logic/reg_port.sv ====
/*
 * Register port
 * Holds pointer and write data and stretches the read and write strobes
 */
`default_nettype none

`include "i2c_macros.svh"

module reg_port
    import i2c_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  ptr_load,
    input  wire logic  wr_load,
    input  wire logic  rd_start,
    input  wire data_t rx_byte,
    output reg_addr_t  reg_addr,
    output data_t      data_out,
    output logic       reg_write,
    output logic       reg_read
);

    localparam int CNT_W = $clog2(`I2C_STROBE_CYCLES + 1);

    // One counter serves both strobes
    logic             strobe_on;
    xfer_dir_e        strobe_kind;
    logic [CNT_W-1:0] strobe_cnt;

    // Pointer survives across transactions
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_addr <= '0;
            data_out <= '0;
        end else begin
            if (ptr_load) begin
                reg_addr <= rx_byte[`I2C_REG_AW-1:0];
            end
            if (wr_load) begin
                data_out <= rx_byte;
            end
        end
    end

    // ======================================================================
    // Strobe stretcher
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_on   <= 1'b0;
            strobe_kind <= WRITE;
            strobe_cnt  <= '0;
        end else if (wr_load || rd_start) begin
            strobe_on   <= 1'b1;
            strobe_kind <= wr_load ? WRITE : READ;
            strobe_cnt  <= '0;
        end else if (strobe_on) begin
            // Drop after the last counted clock
            if (strobe_cnt == CNT_W'(`I2C_STROBE_CYCLES - 1)) begin
                strobe_on <= 1'b0;
            end else begin
                strobe_cnt <= strobe_cnt + 1'b1;
            end
        end
    end

    assign reg_write = strobe_on && (strobe_kind == WRITE);
    assign reg_read  = strobe_on && (strobe_kind == READ);

    // A new load never cuts into a running strobe
    a_strobe_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_load || rd_start) |-> !strobe_on
    );

endmodule

`default_nettype wire

// ==== logic/target_fsm.sv ====
/*
 * I2C target FSM
 * Counts and shifts bits, checks address and register, drives ACK and read data
 */
`default_nettype none

`include "i2c_macros.svh"

module target_fsm
    import i2c_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       sda_sync,
    input  wire logic       scl_rise,
    input  wire logic       scl_fall,
    input  wire logic       start_det,
    input  wire logic       stop_det,
    input  wire logic [2:0] addr_sel,
    input  wire data_t      data_in,
    output logic            sda_drive_low,
    output data_t           rx_byte,
    output logic            ptr_load,
    output logic            wr_load,
    output logic            rd_start
);

    target_state_e state;
    logic [3:0]    bit_cnt;
    xfer_dir_e     dir;
    // Register byte fell in the read-only window
    logic          ro_hit;
    // Remaining read bits with the MSB first
    data_t         tx_byte;

    logic [6:0]    own_addr;
    logic          addr_match;
    logic          reg_ok;
    logic          ro_window;
    logic          byte_done;

    // ======================================================================
    // Decode
    // ======================================================================
    // Strap value added to the base address
    assign own_addr   = `I2C_ADDR_BASE + 7'(addr_sel);
    assign addr_match = (rx_byte[6:0] == own_addr);
    assign reg_ok     = (rx_byte <= `I2C_LAST_REG);
    assign ro_window  = (rx_byte >= `I2C_RO_FIRST) && (rx_byte <= `I2C_RO_LAST);

    // Eighth bit sampled and SCL now low
    assign byte_done  = scl_fall && (bit_cnt == 4'd8);

    // One-clock pulses toward the register port
    assign ptr_load = (state == DEV_REG) && byte_done && reg_ok;
    assign wr_load  = (state == DATA_W) && byte_done && !ro_hit;
    assign rd_start = (state == ACK_ADDR) && scl_fall && (dir == READ);

    // ======================================================================
    // Receive shifter
    // ======================================================================
    always_ff @(posedge clk) begin
        if (scl_rise && (state inside {DEV_ADDR, DEV_REG, DATA_W})) begin
            rx_byte <= {rx_byte[6:0], sda_sync};
        end
    end

    // ======================================================================
    // Transmit shifter
    // ======================================================================
    // MSB goes out with the load and the rest waits here
    always_ff @(posedge clk) begin
        if (rd_start) begin
            tx_byte <= {data_in[6:0], 1'b0};
        end else if (state == DATA_R && scl_fall) begin
            tx_byte <= {tx_byte[6:0], 1'b0};
        end
    end

    // ======================================================================
    // State, bit counter and SDA drive
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            bit_cnt       <= 4'd0;
            dir           <= WRITE;
            ro_hit        <= 1'b0;
            sda_drive_low <= 1'b0;
        end else if (stop_det) begin
            state         <= IDLE;
            bit_cnt       <= 4'd0;
            sda_drive_low <= 1'b0;
        end else if (start_det) begin
            // Repeated START lands here too
            state         <= DEV_ADDR;
            bit_cnt       <= 4'd0;
            sda_drive_low <= 1'b0;
        end else begin
            case (state)
                DEV_ADDR: begin
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end else if (scl_fall && bit_cnt == 4'd7) begin
                        state <= R_W;
                    end
                end
                R_W: begin
                    if (scl_rise) begin
                        dir <= xfer_dir_e'(sda_sync);
                    end else if (scl_fall) begin
                        // Other addresses see SDA left high
                        state         <= addr_match ? ACK_ADDR : NACK;
                        sda_drive_low <= addr_match;
                    end
                end
                ACK_ADDR: begin
                    if (scl_fall) begin
                        if (dir == READ) begin
                            // Bit 7 counts as sent from here
                            state         <= DATA_R;
                            bit_cnt       <= 4'd1;
                            sda_drive_low <= ~data_in[7];
                        end else begin
                            state         <= DEV_REG;
                            bit_cnt       <= 4'd0;
                            sda_drive_low <= 1'b0;
                        end
                    end
                end
                DEV_REG: begin
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end else if (byte_done) begin
                        state         <= reg_ok ? ACK_REG : NACK;
                        sda_drive_low <= reg_ok;
                        ro_hit        <= ro_window;
                    end
                end
                ACK_REG: begin
                    if (scl_fall) begin
                        state         <= DATA_W;
                        bit_cnt       <= 4'd0;
                        sda_drive_low <= 1'b0;
                    end
                end
                DATA_W: begin
                    if (scl_rise) begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end else if (byte_done) begin
                        state         <= ro_hit ? NACK : ACK_DATA;
                        sda_drive_low <= !ro_hit;
                    end
                end
                ACK_DATA: begin
                    if (scl_fall) begin
                        state         <= WAIT;
                        sda_drive_low <= 1'b0;
                    end
                end
                DATA_R: begin
                    if (scl_fall) begin
                        if (bit_cnt == 4'd8) begin
                            // Master ACK or NACK slot is not watched
                            state         <= WAIT;
                            sda_drive_low <= 1'b0;
                        end else begin
                            bit_cnt       <= bit_cnt + 4'd1;
                            sda_drive_low <= ~tx_byte[7];
                        end
                    end
                end
                NACK: begin
                    if (scl_fall) begin
                        state <= WAIT;
                    end
                end
                // IDLE and WAIT leave only on START or STOP
                IDLE, WAIT: begin
                    sda_drive_low <= 1'b0;
                end
                default: begin
                    state         <= IDLE;
                    sda_drive_low <= 1'b0;
                end
            endcase
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    a_no_drive_rx: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state inside {IDLE, DEV_ADDR, DEV_REG}) |-> !sda_drive_low
    );

    // Counter never runs past eight bits
    a_bit_cnt_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        bit_cnt <= 4'd8
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the I2C target testbench with Verilator
# Pass is decided by the pass line in sim.log

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_i2c_target -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb.f ====
+incdir+logic
logic/i2c_pkg.sv
logic/bus_monitor.sv
logic/target_fsm.sv
logic/reg_port.sv
logic/i2c_target.sv
bench/tb_i2c_target.sv
